// ==== verilog/dm_harness_consts.svh ====
// Debug harness constants
`default_nettype none

`ifndef DM_HARNESS_CONSTS_SVH
`define DM_HARNESS_CONSTS_SVH

// ----------------------------------------------------------------------
// DMI bus widths
// ----------------------------------------------------------------------
`define DMI_ADDR_W 7
`define DMI_DATA_W 32

// Cycles after power-on reset before debug requests reach the core
`define DMI_DEL_CYCLES 64

// ----------------------------------------------------------------------
// Debug register map
// ----------------------------------------------------------------------
`define DM_ADDR_DATA0     7'h04
`define DM_ADDR_DATA1     7'h05
`define DM_ADDR_DMCONTROL 7'h10
`define DM_ADDR_DMSTATUS  7'h11

// Reported in dmstatus.version
`define DM_VERSION 4'd2

`endif
`default_nettype wire

// ==== verilog/dm_harness_pkg.sv ====
// Debug harness types
`include "dm_harness_consts.svh"
`default_nettype none

package dm_harness_pkg;

  // DMI operation, code 3 is reserved and handled as a nop
  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2,
    DMI_RSVD  = 2'd3
  } dmi_op_e;

  typedef enum logic [1:0] {
    DMI_SUCCESS = 2'd0,
    DMI_FAILED  = 2'd2
  } dmi_resp_e;

  // ----------------------------------------------------------------------
  // Register layouts
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic        haltreq;
    logic        resumereq;
    logic [27:0] zero1;
    logic        ndmreset;
    logic        dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [22:0] zero1;
    logic        gate_open;
    logic [3:0]  zero0;
    logic [3:0]  version;
  } dmstatus_t;

  // One DMI data word seen raw or through either register layout
  typedef union packed {
    logic [`DMI_DATA_W-1:0] raw;
    dmcontrol_t             ctrl;
    dmstatus_t              status;
  } dm_data_u;

endpackage

`default_nettype wire

// ==== verilog/dmi_if.sv ====
// Debug module interface bus
`timescale 1ns/10ps
`include "dm_harness_consts.svh"
`default_nettype none

interface dmi_if;

  // Request side, stable while req is high
  logic                      req;
  logic [`DMI_ADDR_W-1:0]    addr;
  dm_harness_pkg::dmi_op_e   op;
  logic [`DMI_DATA_W-1:0]    wdata;

  // Response side, valid while ack is high
  logic                      ack;
  dm_harness_pkg::dmi_resp_e resp;
  logic [`DMI_DATA_W-1:0]    rdata;

  // Port mux side
  modport host (
    output req, addr, op, wdata,
    input  ack, resp, rdata
  );

  // Handshake controller only sees the req/ack pair
  modport ctrl (
    input  req,
    output ack
  );

  // Register set side
  modport target (
    input  addr, op, wdata,
    output resp, rdata
  );

endinterface

`default_nettype wire

// ==== verilog/dmi_port_mux.sv ====
// JTAG and DTM port selection
`timescale 1ns/10ps
`include "dm_harness_consts.svh"
`default_nettype none

module dmi_port_mux (
  input  logic                      sel_dtm_i,

  // JTAG side transport
  input  logic                      jtag_req_i,
  input  logic [`DMI_ADDR_W-1:0]    jtag_addr_i,
  input  dm_harness_pkg::dmi_op_e   jtag_op_i,
  input  logic [`DMI_DATA_W-1:0]    jtag_data_i,
  output logic                      jtag_ack_o,
  output dm_harness_pkg::dmi_resp_e jtag_resp_o,
  output logic [`DMI_DATA_W-1:0]    jtag_rdata_o,

  // DTM side transport
  input  logic                      dtm_req_i,
  input  logic [`DMI_ADDR_W-1:0]    dtm_addr_i,
  input  dm_harness_pkg::dmi_op_e   dtm_op_i,
  input  logic [`DMI_DATA_W-1:0]    dtm_data_i,
  output logic                      dtm_ack_o,
  output dm_harness_pkg::dmi_resp_e dtm_resp_o,
  output logic [`DMI_DATA_W-1:0]    dtm_rdata_o,

  dmi_if.host                       dmi
);

  // ----------------------------------------------------------------------
  // Request path
  // ----------------------------------------------------------------------
  assign dmi.req   = sel_dtm_i ? dtm_req_i  : jtag_req_i;
  assign dmi.addr  = sel_dtm_i ? dtm_addr_i : jtag_addr_i;
  assign dmi.op    = sel_dtm_i ? dtm_op_i   : jtag_op_i;
  assign dmi.wdata = sel_dtm_i ? dtm_data_i : jtag_data_i;

  // ----------------------------------------------------------------------
  // Response path
  // ----------------------------------------------------------------------
  // Unselected port never sees an acknowledge
  assign jtag_ack_o = sel_dtm_i ? 1'b0     : dmi.ack;
  assign dtm_ack_o  = sel_dtm_i ? dmi.ack  : 1'b0;

  // Idle port gets a zero response
  always_comb begin : p_resp
    jtag_resp_o  = dm_harness_pkg::DMI_SUCCESS;
    jtag_rdata_o = '0;
    dtm_resp_o   = dm_harness_pkg::DMI_SUCCESS;
    dtm_rdata_o  = '0;
    if (sel_dtm_i) begin
      dtm_resp_o  = dmi.resp;
      dtm_rdata_o = dmi.rdata;
    end else begin
      jtag_resp_o  = dmi.resp;
      jtag_rdata_o = dmi.rdata;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dmi_handshake_fsm.sv ====
// DMI four-phase handshake controller
`timescale 1ns/10ps
`default_nettype none

module dmi_handshake_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  dmi_if.ctrl  dmi,
  output logic exec_o
);

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    EXEC    = 2'd1,
    ACK     = 2'd2,
    RELEASE = 2'd3
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   exec_q;
  logic   ack_q;

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------
  // EXEC lasts two cycles, the second one carries the access strobe
  always_comb begin : p_next_state
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (dmi.req) begin
          state_d = EXEC;
        end
      end
      EXEC: begin
        if (exec_q) begin
          state_d = ACK;
        end
      end
      // Host holding req stalls here, no second access
      ACK: begin
        if (!dmi.req) begin
          state_d = RELEASE;
        end
      end
      RELEASE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // State and output registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= IDLE;
      exec_q  <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      exec_q  <= (state_q == EXEC) && !exec_q;
      // Ack follows ACK state by one edge, so it also drops one edge late
      ack_q   <= (state_q == ACK);
    end
  end

  assign exec_o  = exec_q;
  assign dmi.ack = ack_q;

endmodule

`default_nettype wire

// ==== verilog/dm_regs.sv ====
// Debug register set
`timescale 1ns/10ps
`include "dm_harness_consts.svh"
`default_nettype none

module dm_regs (
  input  logic   clk_i,
  input  logic   rst_ni,
  dmi_if.target  dmi,
  input  logic   exec_i,
  input  logic   gate_open_i,
  output logic   haltreq_o,
  output logic   ndmreset_no
);

  logic [`DMI_DATA_W-1:0]    data0_q;
  logic [`DMI_DATA_W-1:0]    data1_q;
  logic                      haltreq_q;
  logic                      ndmreset_q;
  logic                      dmactive_q;
  dm_harness_pkg::dmi_resp_e resp_q;
  dm_harness_pkg::dmi_resp_e resp_d;
  logic [`DMI_DATA_W-1:0]    rdata_q;
  dm_harness_pkg::dm_data_u  rd_word;
  dm_harness_pkg::dm_data_u  wr_word;
  logic                      data0_we;
  logic                      data1_we;
  logic                      ctrl_we;
  logic                      sys_rst_n;
  logic [1:0]                sync_q;

  assign wr_word = dmi.wdata;

  // ----------------------------------------------------------------------
  // Access decode
  // ----------------------------------------------------------------------
  always_comb begin : p_decode
    rd_word.raw = '0;
    resp_d      = dm_harness_pkg::DMI_SUCCESS;
    data0_we    = 1'b0;
    data1_we    = 1'b0;
    ctrl_we     = 1'b0;
    case (dmi.op)
      dm_harness_pkg::DMI_READ: begin
        case (dmi.addr)
          `DM_ADDR_DATA0: rd_word.raw = data0_q;
          `DM_ADDR_DATA1: rd_word.raw = data1_q;
          `DM_ADDR_DMCONTROL: begin
            // resumereq is write-only and reads back zero
            rd_word.ctrl.haltreq  = haltreq_q;
            rd_word.ctrl.ndmreset = ndmreset_q;
            rd_word.ctrl.dmactive = dmactive_q;
          end
          `DM_ADDR_DMSTATUS: begin
            rd_word.status.gate_open = gate_open_i;
            rd_word.status.version   = `DM_VERSION;
          end
          default: resp_d = dm_harness_pkg::DMI_FAILED;
        endcase
      end
      dm_harness_pkg::DMI_WRITE: begin
        case (dmi.addr)
          `DM_ADDR_DATA0:     data0_we = 1'b1;
          `DM_ADDR_DATA1:     data1_we = 1'b1;
          `DM_ADDR_DMCONTROL: ctrl_we  = 1'b1;
          // dmstatus is read only, writes are dropped
          `DM_ADDR_DMSTATUS:  ;
          default:            resp_d = dm_harness_pkg::DMI_FAILED;
        endcase
      end
      default: ;
    endcase
  end

  // ----------------------------------------------------------------------
  // Registers, updated on the access strobe only
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      data0_q    <= '0;
      data1_q    <= '0;
      haltreq_q  <= 1'b0;
      ndmreset_q <= 1'b0;
      dmactive_q <= 1'b0;
      resp_q     <= dm_harness_pkg::DMI_SUCCESS;
      rdata_q    <= '0;
    end else if (exec_i) begin
      resp_q  <= resp_d;
      rdata_q <= rd_word.raw;
      if (data0_we) begin
        data0_q <= dmi.wdata;
      end
      if (data1_we) begin
        data1_q <= dmi.wdata;
      end
      if (ctrl_we) begin
        haltreq_q  <= wr_word.ctrl.haltreq;
        ndmreset_q <= wr_word.ctrl.ndmreset;
        dmactive_q <= wr_word.ctrl.dmactive;
      end
    end
  end

  assign dmi.resp  = resp_q;
  assign dmi.rdata = rdata_q;
  assign haltreq_o = haltreq_q;

  // System reset, asynchronous on rst_ni, two flops for ndmreset
  assign sys_rst_n = rst_ni & ~ndmreset_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rst_sync
    if (!rst_ni) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], sys_rst_n};
    end
  end

  assign ndmreset_no = sync_q[1];

endmodule

`default_nettype wire

// ==== verilog/debug_req_gate.sv ====
// Startup gate for core debug requests
`timescale 1ns/10ps
`include "dm_harness_consts.svh"
`default_nettype none

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_enable_i,
  input  logic haltreq_i,
  output logic gate_open_o,
  output logic debug_req_o
);

  localparam int unsigned cnt_w = $clog2(`DMI_DEL_CYCLES + 1);

  logic [cnt_w-1:0] cnt_q;
  logic             gate_open;

  // ----------------------------------------------------------------------
  // Delay window counter
  // ----------------------------------------------------------------------
  // Gives the core time to boot before a halt can reach it
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_del_cnt
    if (!rst_ni) begin
      cnt_q <= cnt_w'(`DMI_DEL_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Opens after exactly DMI_DEL_CYCLES edges and stays open
  assign gate_open = (cnt_q == '0);

  // ----------------------------------------------------------------------
  // Request gating
  // ----------------------------------------------------------------------
  assign debug_req_o = gate_open & debug_enable_i & haltreq_i;
  assign gate_open_o = gate_open;

endmodule

`default_nettype wire

// ==== verilog/dm_harness_top.sv ====
// Debug access front end
`timescale 1ns/10ps
`include "dm_harness_consts.svh"
`default_nettype none

module dm_harness_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      sel_dtm_i,
  input  logic                      debug_enable_i,

  // JTAG side DMI port
  input  logic                      jtag_req_i,
  input  logic [`DMI_ADDR_W-1:0]    jtag_addr_i,
  input  dm_harness_pkg::dmi_op_e   jtag_op_i,
  input  logic [`DMI_DATA_W-1:0]    jtag_data_i,
  output logic                      jtag_ack_o,
  output dm_harness_pkg::dmi_resp_e jtag_resp_o,
  output logic [`DMI_DATA_W-1:0]    jtag_rdata_o,

  // DTM side DMI port
  input  logic                      dtm_req_i,
  input  logic [`DMI_ADDR_W-1:0]    dtm_addr_i,
  input  dm_harness_pkg::dmi_op_e   dtm_op_i,
  input  logic [`DMI_DATA_W-1:0]    dtm_data_i,
  output logic                      dtm_ack_o,
  output dm_harness_pkg::dmi_resp_e dtm_resp_o,
  output logic [`DMI_DATA_W-1:0]    dtm_rdata_o,

  // Toward the core and the rest of the system
  output logic                      debug_req_o,
  output logic                      ndmreset_no
);

  logic exec;
  logic haltreq;
  logic gate_open;

  dmi_if u_dmi ();

  dmi_port_mux u_port_mux (
    .sel_dtm_i    ( sel_dtm_i    ),
    .jtag_req_i   ( jtag_req_i   ),
    .jtag_addr_i  ( jtag_addr_i  ),
    .jtag_op_i    ( jtag_op_i    ),
    .jtag_data_i  ( jtag_data_i  ),
    .jtag_ack_o   ( jtag_ack_o   ),
    .jtag_resp_o  ( jtag_resp_o  ),
    .jtag_rdata_o ( jtag_rdata_o ),
    .dtm_req_i    ( dtm_req_i    ),
    .dtm_addr_i   ( dtm_addr_i   ),
    .dtm_op_i     ( dtm_op_i     ),
    .dtm_data_i   ( dtm_data_i   ),
    .dtm_ack_o    ( dtm_ack_o    ),
    .dtm_resp_o   ( dtm_resp_o   ),
    .dtm_rdata_o  ( dtm_rdata_o  ),
    .dmi          ( u_dmi.host   )
  );

  dmi_handshake_fsm u_handshake_fsm (
    .clk_i  ( clk_i      ),
    .rst_ni ( rst_ni     ),
    .dmi    ( u_dmi.ctrl ),
    .exec_o ( exec       )
  );

  dm_regs u_dm_regs (
    .clk_i       ( clk_i        ),
    .rst_ni      ( rst_ni       ),
    .dmi         ( u_dmi.target ),
    .exec_i      ( exec         ),
    .gate_open_i ( gate_open    ),
    .haltreq_o   ( haltreq      ),
    .ndmreset_no ( ndmreset_no  )
  );

  debug_req_gate u_debug_req_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_enable_i ( debug_enable_i ),
    .haltreq_i      ( haltreq        ),
    .gate_open_o    ( gate_open      ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

`default_nettype wire

// ==== bench/dm_harness_assertions.sv ====
// Handshake and reset assertions
`timescale 1ns/10ps
`include "dm_harness_consts.svh"
`default_nettype none

module dm_harness_assertions (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   sel_dtm_i,
  input logic                   jtag_req_i,
  input logic                   dtm_req_i,
  input logic [1:0]             jtag_op_i,
  input logic [1:0]             dtm_op_i,
  input logic [`DMI_ADDR_W-1:0] jtag_addr_i,
  input logic [`DMI_ADDR_W-1:0] dtm_addr_i,
  input logic [`DMI_DATA_W-1:0] jtag_data_i,
  input logic [`DMI_DATA_W-1:0] dtm_data_i,
  input logic                   jtag_ack_o,
  input logic                   dtm_ack_o,
  input logic                   exec_i,
  input logic                   ndmreset_no
);

  logic sel_req;
  logic sel_ack;
  logic ndm_write;

  assign sel_req = sel_dtm_i ? dtm_req_i : jtag_req_i;
  assign sel_ack = jtag_ack_o | dtm_ack_o;

  // Access strobe of a dmcontrol write that sets ndmreset
  assign ndm_write = exec_i
                     && ((sel_dtm_i ? dtm_op_i : jtag_op_i) == dm_harness_pkg::DMI_WRITE)
                     && ((sel_dtm_i ? dtm_addr_i : jtag_addr_i) == `DM_ADDR_DMCONTROL)
                     && (sel_dtm_i ? dtm_data_i[1] : jtag_data_i[1]);

  a_ack_needs_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(sel_ack) |-> sel_req)
    else $error("ack rose without a pending req");

  a_one_ack : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(jtag_ack_o && dtm_ack_o))
    else $error("jtag and dtm ack high together");

  a_ack_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sel_ack && sel_req) |=> sel_ack)
    else $error("ack dropped while req still high");

  // Register update one edge after the strobe, then two synchronizer flops
  a_ndmreset : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ndm_write |=> ##2 !ndmreset_no)
    else $error("ndmreset_no not low two edges after ndmreset set");

endmodule

bind dm_harness_top dm_harness_assertions u_assertions (
  .clk_i       ( clk_i        ),
  .rst_ni      ( rst_ni       ),
  .sel_dtm_i   ( sel_dtm_i    ),
  .jtag_req_i  ( jtag_req_i   ),
  .dtm_req_i   ( dtm_req_i    ),
  .jtag_op_i   ( jtag_op_i    ),
  .dtm_op_i    ( dtm_op_i     ),
  .jtag_addr_i ( jtag_addr_i  ),
  .dtm_addr_i  ( dtm_addr_i   ),
  .jtag_data_i ( jtag_data_i  ),
  .dtm_data_i  ( dtm_data_i   ),
  .jtag_ack_o  ( jtag_ack_o   ),
  .dtm_ack_o   ( dtm_ack_o    ),
  .exec_i      ( exec         ),
  .ndmreset_no ( ndmreset_no  )
);

`default_nettype wire

// ==== bench/tb_dm_harness.sv ====
// Debug front end testbench
`timescale 1ns/10ps
`include "dm_harness_consts.svh"
`default_nettype none

module tb_dm_harness;

  localparam int RST_CYCLES  = 8;
  localparam int N_RAND      = 40;
  localparam int N_FAIL      = 40;
  localparam int ACK_WAIT    = 12;
  localparam int TXN_CYCLES  = 30;
  localparam int WATCHDOG_CYCLES = RST_CYCLES + `DMI_DEL_CYCLES
                                   + (2 * N_RAND + N_FAIL + 12) * TXN_CYCLES;
  // req seen one edge after it is driven, ack registered three edges later
  localparam int ACK_LATENCY = 5;

  logic                      clk;
  logic                      rst_n;
  logic                      sel_dtm;
  logic                      debug_enable;
  logic                      jtag_req;
  logic [`DMI_ADDR_W-1:0]    jtag_addr;
  dm_harness_pkg::dmi_op_e   jtag_op;
  logic [`DMI_DATA_W-1:0]    jtag_data;
  logic                      jtag_ack;
  dm_harness_pkg::dmi_resp_e jtag_resp;
  logic [`DMI_DATA_W-1:0]    jtag_rdata;
  logic                      dtm_req;
  logic [`DMI_ADDR_W-1:0]    dtm_addr;
  dm_harness_pkg::dmi_op_e   dtm_op;
  logic [`DMI_DATA_W-1:0]    dtm_data;
  logic                      dtm_ack;
  dm_harness_pkg::dmi_resp_e dtm_resp;
  logic [`DMI_DATA_W-1:0]    dtm_rdata;
  logic                      debug_req;
  logic                      ndmreset_n;

  int          err_cnt;
  int          test_cnt;
  int          bad_tests;
  int          cyc;
  logic        jtag_guard;
  logic [15:0] lfsr_q;

  // Reference model state
  logic [`DMI_DATA_W-1:0]   m_data0;
  logic [`DMI_DATA_W-1:0]   m_data1;
  dm_harness_pkg::dm_data_u m_ctrl;

  dm_harness_top u_dm_harness_top (
    .clk_i          ( clk          ),
    .rst_ni         ( rst_n        ),
    .sel_dtm_i      ( sel_dtm      ),
    .debug_enable_i ( debug_enable ),
    .jtag_req_i     ( jtag_req     ),
    .jtag_addr_i    ( jtag_addr    ),
    .jtag_op_i      ( jtag_op      ),
    .jtag_data_i    ( jtag_data    ),
    .jtag_ack_o     ( jtag_ack     ),
    .jtag_resp_o    ( jtag_resp    ),
    .jtag_rdata_o   ( jtag_rdata   ),
    .dtm_req_i      ( dtm_req      ),
    .dtm_addr_i     ( dtm_addr     ),
    .dtm_op_i       ( dtm_op       ),
    .dtm_data_i     ( dtm_data     ),
    .dtm_ack_o      ( dtm_ack      ),
    .dtm_resp_o     ( dtm_resp     ),
    .dtm_rdata_o    ( dtm_rdata    ),
    .debug_req_o    ( debug_req    ),
    .ndmreset_no    ( ndmreset_n   )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Edges since reset release, matches the gate counter
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  always @(negedge clk) begin
    if (jtag_guard && jtag_ack) begin
      $display("Unexpected acknowledge on the unselected JTAG port at %0t", $time);
      err_cnt++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic next_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[30:0], lfsr_q[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("Test %0d %s: ok", test_cnt, name);
    end else begin
      bad_tests++;
      $display("Test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  // Predicts the response and updates the model registers
  task automatic model_access(input logic [6:0] addr, input logic [1:0] op,
                              input logic [31:0] wdata, output logic [1:0] resp,
                              output logic [31:0] rdata, output logic rd_valid);
    dm_harness_pkg::dm_data_u w;
    w.raw    = wdata;
    resp     = 2'd0;
    rdata    = '0;
    rd_valid = 1'b1;
    if (op == 2'd1) begin
      case (addr)
        `DM_ADDR_DATA0:     rdata = m_data0;
        `DM_ADDR_DATA1:     rdata = m_data1;
        `DM_ADDR_DMCONTROL: rdata = m_ctrl.raw;
        `DM_ADDR_DMSTATUS: begin
          w.raw = '0;
          w.status.gate_open = (cyc >= `DMI_DEL_CYCLES);
          w.status.version = 4'd2;
          rdata = w.raw;
        end
        default: resp = 2'd2;
      endcase
    end else if (op == 2'd2) begin
      rd_valid = 1'b0;
      case (addr)
        `DM_ADDR_DATA0: m_data0 = wdata;
        `DM_ADDR_DATA1: m_data1 = wdata;
        `DM_ADDR_DMCONTROL: begin
          m_ctrl.raw = '0;
          m_ctrl.ctrl.haltreq  = w.ctrl.haltreq;
          m_ctrl.ctrl.ndmreset = w.ctrl.ndmreset;
          m_ctrl.ctrl.dmactive = w.ctrl.dmactive;
        end
        `DM_ADDR_DMSTATUS: ;
        default: begin
          resp = 2'd2;
          rd_valid = 1'b1;
        end
      endcase
    end
  endtask

  // Four-phase handshake on one port
  task automatic dmi_access(input logic use_dtm, input logic [6:0] addr,
                            input logic [1:0] op, input logic [31:0] wdata,
                            output logic [1:0] resp, output logic [31:0] rdata);
    int   waited;
    logic ack;
    @(posedge clk);
    if (use_dtm) begin
      dtm_req  <= 1'b1;
      dtm_addr <= addr;
      dtm_op   <= dm_harness_pkg::dmi_op_e'(op);
      dtm_data <= wdata;
    end else begin
      jtag_req  <= 1'b1;
      jtag_addr <= addr;
      jtag_op   <= dm_harness_pkg::dmi_op_e'(op);
      jtag_data <= wdata;
    end
    waited = 0;
    ack = 1'b0;
    while (!ack && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
      ack = use_dtm ? dtm_ack : jtag_ack;
    end
    if (!ack) begin
      $display("No acknowledge for the access to address 0x%02h", addr);
      err_cnt++;
    end else begin
      check_value("ack_latency", waited, ACK_LATENCY);
    end
    resp  = use_dtm ? dtm_resp : jtag_resp;
    rdata = use_dtm ? dtm_rdata : jtag_rdata;
    @(posedge clk);
    if (use_dtm) begin
      dtm_req <= 1'b0;
    end else begin
      jtag_req <= 1'b0;
    end
    waited = 0;
    while (ack && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
      ack = use_dtm ? dtm_ack : jtag_ack;
    end
    if (ack) begin
      $display("Acknowledge stayed high after req was dropped");
      err_cnt++;
    end
  endtask

  task automatic checked_access(input logic use_dtm, input logic [6:0] addr,
                                input logic [1:0] op, input logic [31:0] wdata);
    logic [1:0]  exp_resp;
    logic [31:0] exp_rdata;
    logic        rd_valid;
    logic [1:0]  got_resp;
    logic [31:0] got_rdata;
    model_access(addr, op, wdata, exp_resp, exp_rdata, rd_valid);
    dmi_access(use_dtm, addr, op, wdata, got_resp, got_rdata);
    check_value(use_dtm ? "dtm_resp_o" : "jtag_resp_o", got_resp, exp_resp);
    if (rd_valid) begin
      check_value(use_dtm ? "dtm_rdata_o" : "jtag_rdata_o", got_rdata, exp_rdata);
    end
  endtask

  task automatic random_traffic(input logic use_dtm, input int n);
    logic [31:0] pick;
    logic [31:0] op;
    logic [31:0] data;
    for (int i = 0; i < n; i++) begin
      next_bits(1, pick);
      next_bits(2, op);
      next_bits(32, data);
      checked_access(use_dtm, pick[0] ? `DM_ADDR_DATA1 : `DM_ADDR_DATA0, op[1:0], data);
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    int          errs;
    logic [31:0] addr;
    logic [31:0] wr;
    logic [31:0] data;
    clk_init: begin
      rst_n        = 1'b0;
      sel_dtm      = 1'b1;
      debug_enable = 1'b1;
      jtag_req     = 1'b0;
      jtag_addr    = '0;
      jtag_op      = dm_harness_pkg::DMI_NOP;
      jtag_data    = '0;
      dtm_req      = 1'b0;
      dtm_addr     = '0;
      dtm_op       = dm_harness_pkg::DMI_NOP;
      dtm_data     = '0;
    end
    err_cnt    = 0;
    test_cnt   = 0;
    bad_tests  = 0;
    jtag_guard = 1'b0;
    lfsr_q     = 16'd37404;
    m_data0    = '0;
    m_data1    = '0;
    m_ctrl.raw = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // Halt request blocked until the delay window ends
    errs = err_cnt;
    checked_access(1'b1, `DM_ADDR_DMCONTROL, 2'd2, 32'h8000_0001);
    @(negedge clk);
    check_value("debug_req_o", debug_req, 1'b0);
    checked_access(1'b1, `DM_ADDR_DMSTATUS, 2'd1, '0);
    while (cyc < `DMI_DEL_CYCLES) @(negedge clk);
    check_value("debug_req_o", debug_req, 1'b1);
    checked_access(1'b1, `DM_ADDR_DMSTATUS, 2'd1, '0);
    @(posedge clk);
    debug_enable <= 1'b0;
    @(negedge clk);
    check_value("debug_req_o", debug_req, 1'b0);
    @(posedge clk);
    debug_enable <= 1'b1;
    finish_test("gate closed after reset", errs);

    // JTAG request held high while DTM is selected, it must stay unanswered
    errs = err_cnt;
    @(posedge clk);
    jtag_req   <= 1'b1;
    jtag_addr  <= `DM_ADDR_DATA0;
    jtag_op    <= dm_harness_pkg::DMI_WRITE;
    jtag_data  <= 32'hFFFF_FFFF;
    jtag_guard <= 1'b1;
    random_traffic(1'b1, N_RAND);
    @(posedge clk);
    jtag_req   <= 1'b0;
    jtag_guard <= 1'b0;
    finish_test("random traffic on DTM", errs);

    errs = err_cnt;
    @(posedge clk);
    sel_dtm <= 1'b0;
    checked_access(1'b0, `DM_ADDR_DATA0, 2'd1, '0);
    checked_access(1'b0, `DM_ADDR_DATA1, 2'd1, '0);
    random_traffic(1'b0, N_RAND);
    finish_test("switch to JTAG", errs);

    errs = err_cnt;
    for (int i = 0; i < N_FAIL; i++) begin
      next_bits(7, addr);
      while (addr[6:0] == `DM_ADDR_DATA0 || addr[6:0] == `DM_ADDR_DATA1
             || addr[6:0] == `DM_ADDR_DMCONTROL || addr[6:0] == `DM_ADDR_DMSTATUS) begin
        next_bits(7, addr);
      end
      next_bits(1, wr);
      next_bits(32, data);
      checked_access(1'b0, addr[6:0], wr[0] ? 2'd2 : 2'd1, data);
    end
    checked_access(1'b0, `DM_ADDR_DATA0, 2'd1, '0);
    checked_access(1'b0, `DM_ADDR_DATA1, 2'd1, '0);
    checked_access(1'b0, `DM_ADDR_DMCONTROL, 2'd1, '0);
    finish_test("failed response", errs);

    errs = err_cnt;
    checked_access(1'b0, `DM_ADDR_DMCONTROL, 2'd2, 32'h8000_0003);
    @(negedge clk);
    check_value("ndmreset_no", ndmreset_n, 1'b0);
    checked_access(1'b0, `DM_ADDR_DMCONTROL, 2'd1, '0);
    checked_access(1'b0, `DM_ADDR_DMCONTROL, 2'd2, 32'h0000_0001);
    @(negedge clk);
    check_value("ndmreset_no", ndmreset_n, 1'b1);
    finish_test("debug reset", errs);

    $display("Summary: %0d tests, %0d with errors, %0d errors total",
             test_cnt, bad_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/dm_harness_pkg.sv
verilog/dmi_if.sv
verilog/dmi_port_mux.sv
verilog/dmi_handshake_fsm.sv
verilog/dm_regs.sv
verilog/debug_req_gate.sv
verilog/dm_harness_top.sv
bench/dm_harness_assertions.sv
bench/tb_dm_harness.sv

// ==== Bender.yml ====
package:
  name: dm_harness

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/dm_harness_pkg.sv
      - verilog/dmi_if.sv
      - verilog/dmi_port_mux.sv
      - verilog/dmi_handshake_fsm.sv
      - verilog/dm_regs.sv
      - verilog/debug_req_gate.sv
      - verilog/dm_harness_top.sv
  - target: test
    files:
      - bench/dm_harness_assertions.sv
      - bench/tb_dm_harness.sv
